// ==== hw/spiFlashPkg.sv ====
// --------------------
// Offsets are byte addresses on a 5-bit AXI4-Lite bus
// Only whole 32-bit words are decoded
// --------------------
package spiFlashPkg;

	// --------------------
	// Register map
	localparam logic [4:0] ctrlAddr = 5'h00;
	localparam logic [4:0] cmdAddr  = 5'h04;
	localparam logic [4:0] divAddr  = 5'h08;
	localparam logic [4:0] rxAddr   = 5'h0C;
	localparam logic [4:0] statAddr = 5'h10;

	// Control bits, lenLsb is the low bit of a 2-bit field
	localparam int startBit  = 0;
	localparam int addrEnBit = 1;
	localparam int lenLsb    = 4;

	// Status bits
	localparam int busyBit = 0;
	localparam int doneBit = 1;

	// SCK divider after reset
	localparam int defaultDiv = 3;

	// Command word, assembled by fields and sent by bytes
	typedef union packed {
		struct packed {
			logic [7:0]  opcode;
			logic [23:0] addr;
		} f;
		logic [3:0][7:0] bytes;
	} flashCmdU;

endpackage

// ==== hw/spiClockTimer.sv ====
// --------------------
// Tick period is divider + 1 cycles
// First tick comes divider cycles after run rises
// --------------------
`timescale 1ns/1ps

module spiClockTimer #(
	parameter int divWidth = 8
) (
	input  logic                iSCLK,
	input  logic                rstN,
	input  logic                run,
	input  logic [divWidth-1:0] divider,
	output logic                tick
);

	// Down-counter for the SCK half period
	logic [divWidth-1:0] count;

	// Tick on the terminal count only while running
	assign tick = run && (count == '0);

	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			count <= '0;
		end
		else if (!run || (count == '0))
		begin
			// Reload when idle or after each tick
			count <= divider;
		end
		else
		begin
			count <= count - 1'b1;
		end
	end

	// Reload while stopped keeps the first SCK edge a full half period away
	assert property (@(posedge iSCLK) disable iff (!rstN)
		($rose(run) && (divider != '0)) |-> !tick);

endmodule

// ==== hw/spiByteShifter.sv ====
// --------------------
// SPI mode 0 byte engine, holdCycles must be at least 1 and below divider + 1
// --------------------
`timescale 1ns/1ps

module spiByteShifter #(
	parameter int holdCycles = 2
) (
	input  logic       iSCLK,
	input  logic       rstN,
	input  logic       byteEn,
	input  logic       tick,
	input  logic [7:0] txByte,
	input  logic       miso,
	output logic       sck,
	output logic       mosi,
	output logic [7:0] rxByte,
	output logic       byteDone
);

	localparam int holdW = (holdCycles > 1) ? $clog2(holdCycles) : 1;
	localparam logic [holdW-1:0] holdLast = holdW'(holdCycles - 1);

	logic [7:0]       txReg;
	logic [7:0]       rxReg;
	logic [2:0]       negCnt;
	logic [holdW-1:0] holdCnt;
	logic             holdActive;
	logic             sckFall;
	logic             sckRise;
	logic             holdDone;

	// Edge requests, SCK toggles on the following cycle
	assign sckFall  = byteEn && tick && sck;
	assign sckRise  = byteEn && tick && !sck;
	assign holdDone = holdActive && (holdCnt == holdLast);

	// --------------------
	// SCK, edge count and MOSI hold timing
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			sck        <= 1'b0;
			negCnt     <= '0;
			holdCnt    <= '0;
			holdActive <= 1'b0;
			txReg      <= '0;
			byteDone   <= 1'b0;
		end
		else if (!byteEn)
		begin
			// Idle, SCK low and next byte preloaded
			sck        <= 1'b0;
			negCnt     <= '0;
			holdCnt    <= '0;
			holdActive <= 1'b0;
			txReg      <= txByte;
			byteDone   <= 1'b0;
		end
		else
		begin
			if (tick)
				sck <= ~sck;
			// Eighth falling edge ends the byte
			byteDone <= sckFall && (negCnt == 3'd7);
			if (sckFall)
			begin
				negCnt     <= negCnt + 1'b1;
				holdActive <= 1'b1;
				holdCnt    <= '0;
			end
			else if (holdDone)
				holdActive <= 1'b0;
			else if (holdActive)
				holdCnt <= holdCnt + 1'b1;
			// Next bit out once the hold time has passed
			if (holdDone)
				txReg <= {txReg[6:0], 1'b0};
		end
	end

	// --------------------
	// MISO sampled on rising SCK, MSB first
	always_ff @(posedge iSCLK)
	begin
		if (sckRise)
			rxReg <= {rxReg[6:0], miso};
	end

	assign mosi   = txReg[7];
	assign rxByte = rxReg;

	// Sequencer counts bytes on this pulse
	assert property (@(posedge iSCLK) disable iff (!rstN) byteDone |=> !byteDone);

endmodule

// ==== hw/flashSequencer.sv ====
// --------------------
// One read transaction per start, opcode then optional 24-bit address then 1 to 4 bytes
// --------------------
`timescale 1ns/1ps

module flashSequencer import spiFlashPkg::*; (
	input  logic        iSCLK,
	input  logic        rstN,
	input  logic        startPulse,
	input  logic        addrEn,
	input  logic [1:0]  dataLen,
	input  flashCmdU    cmdWord,
	input  logic        byteDone,
	input  logic [7:0]  rxByte,
	output logic        byteEn,
	output logic [7:0]  txByte,
	output logic        run,
	output logic        csN,
	output logic        busy,
	output logic        done,
	output logic [31:0] rxWord
);

	localparam logic [2:0] sIdle     = 3'd0;
	localparam logic [2:0] sSelect   = 3'd1;
	localparam logic [2:0] sHeader   = 3'd2;
	localparam logic [2:0] sData     = 3'd3;
	localparam logic [2:0] sDeselect = 3'd4;

	logic [2:0] state;
	flashCmdU   cmdReg;
	logic       addrEnReg;
	logic [1:0] lenReg;
	logic [1:0] byteIdx;
	logic [1:0] dataCnt;

	// Timer runs only while a byte is on the wire
	assign run = byteEn;

	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			state     <= sIdle;
			cmdReg    <= '0;
			addrEnReg <= 1'b0;
			lenReg    <= '0;
			byteIdx   <= '0;
			dataCnt   <= '0;
			byteEn    <= 1'b0;
			txByte    <= '0;
			csN       <= 1'b1;
			busy      <= 1'b0;
			done      <= 1'b0;
			rxWord    <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				sIdle:
				begin
					// Latch the request, CS drops next cycle
					if (startPulse)
					begin
						cmdReg    <= cmdWord;
						addrEnReg <= addrEn;
						lenReg    <= dataLen;
						csN       <= 1'b0;
						busy      <= 1'b1;
						state     <= sSelect;
					end
				end
				sSelect:
				begin
					// Opcode first
					txByte  <= cmdReg.bytes[3];
					byteIdx <= 2'd3;
					state   <= sHeader;
				end
				sHeader:
				begin
					if (!byteEn)
						byteEn <= 1'b1;
					else if (byteDone)
					begin
						// One low cycle lets the engine reload
						byteEn <= 1'b0;
						if (addrEnReg && (byteIdx != 2'd0))
						begin
							byteIdx <= byteIdx - 1'b1;
							txByte  <= cmdReg.bytes[byteIdx - 1'b1];
						end
						else
						begin
							// Dummy zeros while reading
							txByte  <= '0;
							dataCnt <= '0;
							rxWord  <= '0;
							state   <= sData;
						end
					end
				end
				sData:
				begin
					if (!byteEn)
						byteEn <= 1'b1;
					else if (byteDone)
					begin
						byteEn                <= 1'b0;
						rxWord[dataCnt*8 +: 8] <= rxByte;
						dataCnt               <= dataCnt + 1'b1;
						if (dataCnt == lenReg)
							state <= sDeselect;
					end
				end
				sDeselect:
				begin
					// Busy falls with the done pulse
					csN   <= 1'b1;
					busy  <= 1'b0;
					done  <= 1'b1;
					state <= sIdle;
				end
				default:
					state <= sIdle;
			endcase
		end
	end

	// CS may only rise from the deselect state
	assert property (@(posedge iSCLK) disable iff (!rstN)
		(!csN && (state != sDeselect)) |=> !csN);
	// CSR gates start with busy
	assert property (@(posedge iSCLK) disable iff (!rstN) startPulse |-> !busy);

endmodule

// ==== hw/spiFlashCsr.sv ====
// --------------------
// AXI4-Lite slave, OKAY responses only and wstrb is not decoded
// --------------------
`timescale 1ns/1ps

module spiFlashCsr import spiFlashPkg::*; #(
	parameter int divWidth = 8
) (
	input  logic                iSCLK,
	input  logic                rstN,
	// AXI4-Lite slave
	input  logic [4:0]          awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [31:0]         wdata,
	input  logic [3:0]          wstrb,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [4:0]          araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [31:0]         rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,
	// Sequencer side
	input  logic                busy,
	input  logic                done,
	input  logic [31:0]         rxWord,
	output logic                startPulse,
	output logic                addrEn,
	output logic [1:0]          dataLen,
	output flashCmdU            cmdWord,
	output logic [divWidth-1:0] divider
);

	logic        wrEn;
	logic        rdEn;
	logic        doneSticky;
	logic [31:0] readMux;

	// Transfer cycles
	assign wrEn = awready && awvalid && wready && wvalid;
	assign rdEn = arready && arvalid;

	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// --------------------
	// Handshakes and control registers
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			awready    <= 1'b0;
			wready     <= 1'b0;
			bvalid     <= 1'b0;
			arready    <= 1'b0;
			rvalid     <= 1'b0;
			startPulse <= 1'b0;
			addrEn     <= 1'b0;
			dataLen    <= '0;
			divider    <= divWidth'(defaultDiv);
			doneSticky <= 1'b0;
		end
		else
		begin
			// Single-cycle ready, held off while a response waits
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready  <= awvalid && wvalid && !awready && !bvalid;
			arready <= arvalid && !arready && !rvalid;

			if (wrEn)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rdEn)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;

			// Start self-clears, dropped while a transaction runs
			startPulse <= wrEn && (awaddr == ctrlAddr) && wdata[startBit] && !busy;

			if (wrEn && (awaddr == ctrlAddr))
			begin
				addrEn  <= wdata[addrEnBit];
				dataLen <= wdata[lenLsb +: 2];
			end
			if (wrEn && (awaddr == divAddr))
				divider <= wdata[divWidth-1:0];

			// Done set wins over a clear in the same cycle
			if (done)
				doneSticky <= 1'b1;
			else if (wrEn && (awaddr == statAddr) && wdata[doneBit])
				doneSticky <= 1'b0;
		end
	end

	// --------------------
	// Command word and read data
	always_ff @(posedge iSCLK)
	begin
		if (wrEn && (awaddr == cmdAddr))
		begin
			cmdWord.f.opcode <= wdata[31:24];
			cmdWord.f.addr   <= wdata[23:0];
		end
		if (rdEn)
			rdata <= readMux;
	end

	// Unmapped offsets read zero
	always_comb
	begin
		readMux = '0;
		case (araddr)
			ctrlAddr:
			begin
				readMux[addrEnBit]    = addrEn;
				readMux[lenLsb +: 2] = dataLen;
			end
			cmdAddr:
				readMux = cmdWord;
			divAddr:
				readMux[divWidth-1:0] = divider;
			rxAddr:
				readMux = rxWord;
			statAddr:
			begin
				readMux[busyBit] = busy;
				readMux[doneBit] = doneSticky;
			end
			default:
				readMux = '0;
		endcase
	end

	// Write response must wait for the master
	assert property (@(posedge iSCLK) disable iff (!rstN) (bvalid && !bready) |=> bvalid);

endmodule

// ==== hw/spiFlashCtrl.sv ====
// --------------------
// SPI flash read controller, holdCycles must stay below divider + 1
// --------------------
`timescale 1ns/1ps

module spiFlashCtrl import spiFlashPkg::*; #(
	parameter int divWidth   = 8,
	parameter int holdCycles = 2
) (
	input  logic        iSCLK,
	input  logic        rstN,
	// AXI4-Lite slave
	input  logic [4:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [4:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	// Flash pins
	output logic        flashSck,
	output logic        flashMosi,
	input  logic        flashMiso,
	output logic        flashCsN
);

	// CSR to sequencer
	logic                startPulse;
	logic                addrEn;
	logic [1:0]          dataLen;
	flashCmdU            cmdWord;
	logic [divWidth-1:0] divider;
	logic                busy;
	logic                done;
	logic [31:0]         rxWord;
	// Sequencer to byte engine and timer
	logic                byteEn;
	logic [7:0]          txByte;
	logic                run;
	logic                tick;
	logic                byteDone;
	logic [7:0]          rxByte;

	spiFlashCsr #(
		.divWidth(divWidth)
	) csr (
		.iSCLK(iSCLK), .rstN(rstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.busy(busy), .done(done), .rxWord(rxWord),
		.startPulse(startPulse), .addrEn(addrEn), .dataLen(dataLen),
		.cmdWord(cmdWord), .divider(divider)
	);

	flashSequencer seq (
		.iSCLK(iSCLK), .rstN(rstN),
		.startPulse(startPulse), .addrEn(addrEn), .dataLen(dataLen),
		.cmdWord(cmdWord), .byteDone(byteDone), .rxByte(rxByte),
		.byteEn(byteEn), .txByte(txByte), .run(run), .csN(flashCsN),
		.busy(busy), .done(done), .rxWord(rxWord)
	);

	spiClockTimer #(
		.divWidth(divWidth)
	) timer (
		.iSCLK(iSCLK), .rstN(rstN),
		.run(run), .divider(divider), .tick(tick)
	);

	spiByteShifter #(
		.holdCycles(holdCycles)
	) shifter (
		.iSCLK(iSCLK), .rstN(rstN),
		.byteEn(byteEn), .tick(tick), .txByte(txByte), .miso(flashMiso),
		.sck(flashSck), .mosi(flashMosi), .rxByte(rxByte), .byteDone(byteDone)
	);

endmodule

// ==== sim/tbClockGen.sv ====
// --------------------
// 40 ns clock, reset low for the first 8 rising edges
// --------------------
`timescale 1ns/1ps

module tbClockGen #(
	parameter int halfPeriod  = 20,
	parameter int resetCycles = 8
) (
	output logic clk,
	output logic rstN
);

	initial
	begin
		clk = 1'b0;
		forever
			#halfPeriod clk = ~clk;
	end

	// Release on a rising edge
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles)
			@(posedge clk);
		rstN <= 1'b1;
	end

endmodule

// ==== sim/flashModel.sv ====
// --------------------
// Mode 0 read-only flash, every opcode reads, address phase only while addrEn is high
// --------------------
`timescale 1ns/1ps

module flashModel (
	input  logic        sck,
	input  logic        mosi,
	input  logic        csN,
	input  logic        addrEn,
	output logic        miso,
	output logic [7:0]  opcode,
	output logic [23:0] address,
	output logic [31:0] bitCount
);

	localparam logic [7:0] dataMask = 8'h5A;

	logic [31:0] shiftIn;
	logic [31:0] hdrBits;
	logic [31:0] dataIdx;
	logic [23:0] base;
	logic [7:0]  dataByte;

	initial
	begin
		miso     = 1'b0;
		opcode   = '0;
		address  = '0;
		bitCount = '0;
		shiftIn  = '0;
	end

	// --------------------
	// Header capture on rising SCK
	always @(posedge sck or negedge csN)
	begin
		if (!sck)
		begin
			// CS just fell, new transaction
			bitCount <= '0;
			shiftIn  <= '0;
			address  <= '0;
		end
		else if (!csN)
		begin
			shiftIn  <= {shiftIn[30:0], mosi};
			bitCount <= bitCount + 1;
			if (bitCount == 32'd7)
				opcode <= {shiftIn[6:0], mosi};
			if (addrEn && (bitCount == 32'd31))
				address <= {shiftIn[22:0], mosi};
		end
	end

	// Opcode only, or opcode plus three address bytes
	assign hdrBits  = addrEn ? 32'd32 : 32'd8;
	assign base     = addrEn ? address : 24'h0;
	// Bit that the next rising edge samples
	assign dataIdx  = bitCount - hdrBits;
	assign dataByte = (base[7:0] + 8'(dataIdx >> 3)) ^ dataMask;

	// Data out on falling SCK, MSB first
	always @(negedge sck)
	begin
		if (!csN && (bitCount >= hdrBits))
			miso <= dataByte[3'd7 - dataIdx[2:0]];
	end

endmodule

// ==== sim/tbSpiFlashCtrl.sv ====
// --------------------
// Table rows keep the divider at 2 or more, since holdCycles is 2
// --------------------
`timescale 1ns/1ps

module tbSpiFlashCtrl import spiFlashPkg::*; ();

	localparam int          timeoutCycles = 20000;
	localparam int          numRows       = 8;
	localparam logic [31:0] seed          = 32'd57720;
	localparam logic [7:0]  dataMask      = 8'h5A;

	typedef struct packed {
		logic [7:0]  opcode;
		logic [23:0] addr;
		logic        addrEn;
		logic [1:0]  len;
		logic [7:0]  div;
		logic        stall;
		logic [31:0] expRx;
	} rowT;

	logic        clk;
	logic        rstN;
	logic [4:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [4:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        flashSck;
	logic        flashMosi;
	logic        flashMiso;
	logic        flashCsN;
	logic        modelAddrEn;
	logic [7:0]  modelOpcode;
	logic [23:0] modelAddr;
	logic [31:0] modelBits;

	rowT         rows [0:numRows-1];
	logic [31:0] rngState;
	bit          hung;
	int          errors;
	int          errAtStart;
	int          testNum;
	int          testsPassed;
	int          testsFailed;

	tbClockGen clkGen (.clk(clk), .rstN(rstN));

	spiFlashCtrl #(.divWidth(8), .holdCycles(2)) UUT (
		.iSCLK(clk), .rstN(rstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.flashSck(flashSck), .flashMosi(flashMosi), .flashMiso(flashMiso),
		.flashCsN(flashCsN)
	);

	flashModel model (
		.sck(flashSck), .mosi(flashMosi), .csN(flashCsN), .addrEn(modelAddrEn),
		.miso(flashMiso), .opcode(modelOpcode), .address(modelAddr), .bitCount(modelBits)
	);

	// --------------------
	// Random numbers and expected values
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// Master stall of 1 to 6 cycles
	function automatic int drawStall();
		return 1 + int'(nextRandom() % 32'd6);
	endfunction

	// Data byte i is (address + i) low byte XOR 0x5A, byte 0 first
	function automatic logic [31:0] ruleWord(input logic [23:0] base, input logic [1:0] len);
		logic [31:0] w;
		int          i;
		w = '0;
		for (i = 0; i <= int'(len); i++)
			w[i*8 +: 8] = (base[7:0] + 8'(i)) ^ dataMask;
		return w;
	endfunction

	function automatic logic [31:0] ctrlValue(input logic withAddr, input logic [1:0] len);
		logic [31:0] v;
		v = '0;
		v[startBit]    = 1'b1;
		v[addrEnBit]   = withAddr;
		v[lenLsb +: 2] = len;
		return v;
	endfunction

	task automatic setRow(input int idx, input logic [7:0] op, input logic withAddr,
		input logic [1:0] len, input logic [7:0] div, input logic stall);
		logic [31:0] r;
		r = nextRandom();
		rows[idx].opcode = op;
		rows[idx].addr   = r[23:0];
		rows[idx].addrEn = withAddr;
		rows[idx].len    = len;
		rows[idx].div    = div;
		rows[idx].stall  = stall;
		// Opcode-only reads start at address 0
		rows[idx].expRx  = ruleWord(withAddr ? r[23:0] : 24'h0, len);
	endtask

	// --------------------
	// Checks and reporting
	task automatic noteTimeout(input string what);
		$display("timeout at %0t: no %s within %0d cycles", $time, what, timeoutCycles);
		errors++;
		hung = 1'b1;
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (hung)
			return;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkPin(input string name, input logic got, input logic exp);
		if (hung)
			return;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkCmd(input string name, input flashCmdU got, input flashCmdU exp);
		if (hung)
			return;
		if (got.f.opcode !== exp.f.opcode)
		begin
			errors++;
			$display("error at %0t: %s.opcode got %h, expected %h", $time, name,
				got.f.opcode, exp.f.opcode);
		end
		if (got.f.addr !== exp.f.addr)
		begin
			errors++;
			$display("error at %0t: %s.addr got %h, expected %h", $time, name,
				got.f.addr, exp.f.addr);
		end
	endtask

	task automatic endTest(input string name);
		testNum++;
		if (errors == errAtStart)
		begin
			testsPassed++;
			$display("test %0d %s: ok", testNum, name);
		end
		else
		begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testNum, name, errors - errAtStart);
		end
		errAtStart = errors;
	endtask

	// --------------------
	// AXI4-Lite master
	task automatic axiWrite(input logic [4:0] addr, input logic [31:0] data, input logic stall);
		int n;
		int delay;
		if (hung)
			return;
		delay = stall ? drawStall() : 0;
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wvalid  <= 1'b1;
		n = 0;
		@(posedge clk);
		while (!(awready && wready) && !hung)
		begin
			n++;
			if (n >= timeoutCycles)
				noteTimeout("awready and wready");
			@(posedge clk);
		end
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		n = 0;
		@(posedge clk);
		while (!bvalid && !hung)
		begin
			n++;
			if (n >= timeoutCycles)
				noteTimeout("bvalid");
			@(posedge clk);
		end
		// Held off by the master, response must stay
		repeat (delay)
		begin
			@(posedge clk);
			checkPin("bvalid", bvalid, 1'b1);
		end
		checkWord("bresp", 32'(bresp), 32'h0);
		bready <= 1'b1;
		@(posedge clk);
		checkPin("bvalid", bvalid, 1'b1);
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [4:0] addr, input logic stall, output logic [31:0] data);
		int n;
		int delay;
		data = '0;
		if (hung)
			return;
		delay = stall ? drawStall() : 0;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		n = 0;
		@(posedge clk);
		while (!arready && !hung)
		begin
			n++;
			if (n >= timeoutCycles)
				noteTimeout("arready");
			@(posedge clk);
		end
		arvalid <= 1'b0;
		n = 0;
		@(posedge clk);
		while (!rvalid && !hung)
		begin
			n++;
			if (n >= timeoutCycles)
				noteTimeout("rvalid");
			@(posedge clk);
		end
		data = rdata;
		repeat (delay)
		begin
			@(posedge clk);
			checkPin("rvalid", rvalid, 1'b1);
			checkWord("rdata", rdata, data);
		end
		checkWord("rresp", 32'(rresp), 32'h0);
		rready <= 1'b1;
		@(posedge clk);
		checkPin("rvalid", rvalid, 1'b1);
		rready <= 1'b0;
	endtask

	// Poll status until the sticky done bit shows
	task automatic waitDone(input logic stall);
		logic [31:0] stat;
		int          polls;
		stat  = '0;
		polls = 0;
		while (!stat[doneBit] && !hung)
		begin
			axiRead(statAddr, stall, stat);
			// Idle FSM means CS released
			if (!stat[busyBit])
				checkPin("flashCsN", flashCsN, 1'b1);
			polls++;
			if (polls >= timeoutCycles / 4)
				noteTimeout("done bit in status");
		end
	endtask

	// --------------------
	// Tests
	task automatic checkResetState();
		logic [31:0] got;
		checkPin("flashCsN", flashCsN, 1'b1);
		checkPin("flashSck", flashSck, 1'b0);
		checkPin("bvalid", bvalid, 1'b0);
		checkPin("rvalid", rvalid, 1'b0);
		axiRead(statAddr, 1'b0, got);
		checkWord("status", got, 32'h0);
		axiRead(divAddr, 1'b0, got);
		checkWord("divider", got, 32'(defaultDiv));
		endTest("reset state");
	endtask

	task automatic checkReadback();
		logic [31:0] val;
		logic [31:0] got;
		val = nextRandom();
		axiWrite(divAddr, {24'h0, val[7:0]}, 1'b0);
		axiRead(divAddr, 1'b0, got);
		checkWord("divider", got, {24'h0, val[7:0]});
		val = nextRandom();
		axiWrite(cmdAddr, val, 1'b0);
		axiRead(cmdAddr, 1'b0, got);
		checkWord("cmdWord", got, val);
		endTest("register readback");
	endtask

	task automatic runRow(input int idx);
		rowT         r;
		logic [31:0] got;
		flashCmdU    expCmd;
		flashCmdU    seen;
		int          bits;
		r = rows[idx];
		modelAddrEn <= r.addrEn;
		axiWrite(divAddr, {24'h0, r.div}, r.stall);
		axiWrite(cmdAddr, {r.opcode, r.addr}, r.stall);
		axiWrite(ctrlAddr, ctrlValue(r.addrEn, r.len), r.stall);
		waitDone(r.stall);
		axiRead(rxAddr, r.stall, got);
		checkWord("rxWord", got, r.expRx);
		// What the flash saw on the wire
		expCmd.f.opcode = r.opcode;
		expCmd.f.addr   = r.addrEn ? r.addr : 24'h0;
		seen.f.opcode   = modelOpcode;
		seen.f.addr     = modelAddr;
		checkCmd("flash command", seen, expCmd);
		bits = 8 + 8 * (int'(r.len) + 1);
		if (r.addrEn)
			bits += 24;
		checkWord("flash bit count", modelBits, 32'(bits));
		// Clear done, back to an idle status
		axiWrite(statAddr, 32'(1) << doneBit, r.stall);
		axiRead(statAddr, r.stall, got);
		checkWord("status", got, 32'h0);
		checkPin("flashCsN", flashCsN, 1'b1);
		endTest($sformatf("row %0d opcode %h len %0d div %0d", idx, r.opcode,
			int'(r.len) + 1, r.div));
	endtask

	task automatic startWhileBusy();
		logic [31:0] stat;
		logic [31:0] got;
		logic [31:0] r;
		r = nextRandom();
		modelAddrEn <= 1'b1;
		axiWrite(divAddr, 32'd3, 1'b0);
		axiWrite(cmdAddr, {8'h03, r[23:0]}, 1'b0);
		axiWrite(ctrlAddr, ctrlValue(1'b1, 2'd3), 1'b0);
		axiRead(statAddr, 1'b0, stat);
		checkPin("busy", stat[busyBit], 1'b1);
		// Second start lands mid-transaction
		axiWrite(ctrlAddr, ctrlValue(1'b0, 2'd0), 1'b0);
		waitDone(1'b0);
		axiRead(rxAddr, 1'b0, got);
		checkWord("rxWord", got, ruleWord(r[23:0], 2'd3));
		checkWord("flash bit count", modelBits, 32'd64);
		axiRead(statAddr, 1'b0, stat);
		checkWord("status", stat, 32'(1) << doneBit);
		axiWrite(statAddr, 32'(1) << doneBit, 1'b0);
		axiRead(statAddr, 1'b0, stat);
		checkWord("status", stat, 32'h0);
		endTest("start while busy and done clear");
	endtask

	// --------------------
	initial
	begin
		int n;
		int i;
		awaddr      = '0;
		awvalid     = 1'b0;
		wdata       = '0;
		wstrb       = 4'hF;
		wvalid      = 1'b0;
		bready      = 1'b0;
		araddr      = '0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		modelAddrEn = 1'b0;
		rngState    = seed;
		hung        = 1'b0;
		errors      = 0;
		errAtStart  = 0;
		testNum     = 0;
		testsPassed = 0;
		testsFailed = 0;

		// Opcode, addrEn, length - 1, divider, stall
		setRow(0, 8'h03, 1'b1, 2'd0, 8'd2, 1'b0);
		setRow(1, 8'h03, 1'b1, 2'd1, 8'd3, 1'b0);
		setRow(2, 8'h0B, 1'b1, 2'd2, 8'd5, 1'b0);
		setRow(3, 8'h03, 1'b1, 2'd3, 8'd2, 1'b0);
		setRow(4, 8'h9F, 1'b0, 2'd2, 8'd3, 1'b0);
		setRow(5, 8'h05, 1'b0, 2'd0, 8'd4, 1'b1);
		setRow(6, 8'h03, 1'b1, 2'd3, 8'd7, 1'b1);
		setRow(7, 8'h4B, 1'b0, 2'd3, 8'd2, 1'b1);

		n = 0;
		@(posedge clk);
		while (!rstN && !hung)
		begin
			n++;
			if (n >= timeoutCycles)
				noteTimeout("reset release");
			@(posedge clk);
		end
		@(posedge clk);

		checkResetState();
		checkReadback();
		for (i = 0; (i < numRows) && !hung; i++)
			runRow(i);
		if (!hung)
			startWhileBusy();

		$display("summary: %0d tests passed, %0d tests failed", testsPassed, testsFailed);
		if ((testsFailed == 0) && (errors == 0))
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== spiFlashCtrl.f ====
hw/spiFlashPkg.sv
hw/spiClockTimer.sv
hw/spiByteShifter.sv
hw/flashSequencer.sv
hw/spiFlashCsr.sv
hw/spiFlashCtrl.sv
sim/tbClockGen.sv
sim/flashModel.sv
sim/tbSpiFlashCtrl.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tbSpiFlashCtrl
FILELIST := spiFlashCtrl.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
PASSMSG  := Test completed successfully
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -qx "$(PASSMSG)" $(LOG); then echo "PASS"; \
	else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
